// ==== rtl/lsu_params.svh ====
// LSU store path parameters for widths, queue depths and memory credits
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath and ROB widths
`define LSU_DATA_WIDTH      32
`define LSU_ADDR_WIDTH      16
`define LSU_TAG_WIDTH       5
`define LSU_SQ_DEPTH        4

// Cache geometry, one 32-bit word per line
`define LSU_DC_LINE_WIDTH   2
`define LSU_DC_SET_WIDTH    3
`define LSU_DC_WAYS         2
`define LSU_DC_WAY_WIDTH    1
`define LSU_DC_TAG_WIDTH    11

// Miss holding queue and memory flow control
`define LSU_MSHQ_DEPTH      2
`define LSU_MEM_CREDITS     2
`endif

// ==== rtl/lsu_pkg.sv ====
// LSU package with the datapath vector types and the store type encoding
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // Store data and byte addresses
    typedef logic [`LSU_DATA_WIDTH-1:0]   data_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`LSU_TAG_WIDTH-1:0]    rob_tag_t;

    // Cache lookup fields split out of an address
    typedef logic [`LSU_DC_SET_WIDTH-1:0] dc_set_t;
    typedef logic [`LSU_DC_WAY_WIDTH-1:0] dc_way_t;
    typedef logic [`LSU_DC_TAG_WIDTH-1:0] dc_tag_t;

    // One enable per byte of a data word
    typedef logic [`LSU_DATA_WIDTH/8-1:0] byte_mask_t;

    // Store width, byte and halfword stores land in the low bits of the word
    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2
    } lsu_func_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_sq.sv ====
// Store queue holding issued stores until the ROB retires them into the cache or miss queue
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_sq (
    input  wire                        clk,
    input  wire                        n_rst,
    input  wire                        i_flush,
    output logic                       o_full,
    input  wire                        i_alloc_en,
    input  wire lsu_pkg::data_t        i_alloc_data,
    input  wire lsu_pkg::addr_t        i_alloc_addr,
    input  wire lsu_pkg::lsu_func_t    i_alloc_func,
    input  wire lsu_pkg::rob_tag_t     i_alloc_tag,
    input  wire                        i_rob_retire_en,
    input  wire lsu_pkg::rob_tag_t     i_rob_retire_tag,
    output logic                       o_rob_retire_stall,
    output lsu_pkg::dc_set_t           o_dc_set,
    output lsu_pkg::dc_tag_t           o_dc_tag,
    input  wire                        i_dc_hit,
    input  wire lsu_pkg::data_t        i_dc_data,
    output logic                       o_dc_wr_en,
    output lsu_pkg::data_t             o_dc_wr_data,
    output logic                       o_mshq_push,
    output lsu_pkg::addr_t             o_mshq_addr,
    output lsu_pkg::data_t             o_mshq_data,
    output lsu_pkg::byte_mask_t        o_mshq_mask,
    input  wire                        i_mshq_full
);

    localparam int DEPTH  = `LSU_SQ_DEPTH;
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int SET_LO = `LSU_DC_LINE_WIDTH;
    localparam int TAG_LO = `LSU_DC_LINE_WIDTH + `LSU_DC_SET_WIDTH;

    // Slot contents, only the valid bits are control state
    logic [DEPTH-1:0]   slot_valid;
    lsu_pkg::addr_t     slot_addr [DEPTH];
    lsu_pkg::data_t     slot_data [DEPTH];
    lsu_pkg::lsu_func_t slot_func [DEPTH];
    lsu_pkg::rob_tag_t  slot_tag  [DEPTH];

    logic [DEPTH-1:0]   alloc_sel;
    logic [DEPTH-1:0]   retire_match;
    logic [IDX_W-1:0]   retire_idx;
    logic               allocating;
    logic               retiring;
    logic               retire_miss;
    lsu_pkg::addr_t     ret_addr;

    // Lowest clear valid bit picks the slot for the next store
    assign alloc_sel  = ~slot_valid & (slot_valid + 1'b1);
    assign o_full     = &slot_valid;
    assign allocating = i_alloc_en && !o_full;

    // The ROB tag names exactly one live slot
    always_comb begin
        retire_match = '0;
        retire_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            retire_match[i] = slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
            if (retire_match[i]) begin
                retire_idx = retire_idx | IDX_W'(i);
            end
        end
    end

    // Split the retiring address into cache set and tag
    assign ret_addr = slot_addr[retire_idx];
    assign o_dc_set = ret_addr[TAG_LO-1:SET_LO];
    assign o_dc_tag = ret_addr[`LSU_ADDR_WIDTH-1:TAG_LO];

    // Sub-word stores replace the low bits of the cached word
    always_comb begin
        case (slot_func[retire_idx])
            lsu_pkg::SB: begin
                o_dc_wr_data = {i_dc_data[`LSU_DATA_WIDTH-1:8], slot_data[retire_idx][7:0]};
                o_mshq_mask  = 4'b0001;
            end
            lsu_pkg::SH: begin
                o_dc_wr_data = {i_dc_data[`LSU_DATA_WIDTH-1:16], slot_data[retire_idx][15:0]};
                o_mshq_mask  = 4'b0011;
            end
            default: begin
                o_dc_wr_data = slot_data[retire_idx];
                o_mshq_mask  = 4'b1111;
            end
        endcase
    end

    // A hit writes the cache, a miss goes to the miss queue or stalls the ROB
    assign retire_miss        = i_rob_retire_en && !i_dc_hit;
    assign o_rob_retire_stall = retire_miss && i_mshq_full;
    assign retiring           = i_rob_retire_en && !o_rob_retire_stall;
    assign o_dc_wr_en         = i_rob_retire_en && i_dc_hit;
    assign o_mshq_push        = retire_miss && !i_mshq_full;
    assign o_mshq_addr        = {ret_addr[`LSU_ADDR_WIDTH-1:SET_LO], {SET_LO{1'b0}}};
    assign o_mshq_data        = slot_data[retire_idx];

    // Flush empties every slot, allocation and retire never touch the same slot
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retiring && retire_match[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Payload is captured on allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_func[i] <= i_alloc_func;
                slot_tag[i]  <= i_alloc_tag;
            end
        end
    end

    // ROB tags of live stores stay unique
    a_retire_unique: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(retire_match));

    // The ROB only retires a store that was allocated earlier
    a_retire_found: assert property (@(posedge clk) disable iff (!n_rst)
        i_rob_retire_en |-> |retire_match);

endmodule

`default_nettype wire

// ==== rtl/lsu_dcache.sv ====
// Two-way set-associative data cache with store lookup, load lookup, store write and fill
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_dcache (
    input  wire                     clk,
    input  wire                     n_rst,
    input  wire lsu_pkg::dc_set_t   i_lookup_set,
    input  wire lsu_pkg::dc_tag_t   i_lookup_tag,
    output logic                    o_hit,
    output lsu_pkg::dc_way_t        o_hit_way,
    output lsu_pkg::data_t          o_hit_data,
    input  wire                     i_wr_en,
    input  wire lsu_pkg::data_t     i_wr_data,
    input  wire lsu_pkg::addr_t     i_ld_addr,
    output logic                    o_ld_hit,
    output lsu_pkg::data_t          o_ld_data,
    input  wire                     i_fill_en,
    input  wire lsu_pkg::addr_t     i_fill_addr,
    input  wire lsu_pkg::data_t     i_fill_data
);

    localparam int WAYS   = `LSU_DC_WAYS;
    localparam int SETS   = 1 << `LSU_DC_SET_WIDTH;
    localparam int SET_LO = `LSU_DC_LINE_WIDTH;
    localparam int TAG_LO = `LSU_DC_LINE_WIDTH + `LSU_DC_SET_WIDTH;

    // Per way and set storage with one word per line
    logic             line_valid [WAYS][SETS];
    lsu_pkg::dc_tag_t line_tag   [WAYS][SETS];
    lsu_pkg::data_t   line_data  [WAYS][SETS];

    // Round robin replacement state per set
    lsu_pkg::dc_way_t victim [SETS];

    lsu_pkg::dc_set_t ld_set;
    lsu_pkg::dc_set_t fill_set;
    lsu_pkg::dc_way_t fill_way;

    assign ld_set   = i_ld_addr[TAG_LO-1:SET_LO];
    assign fill_set = i_fill_addr[TAG_LO-1:SET_LO];
    assign fill_way = victim[fill_set];

    // Searches both ways of one set and returns the matching way
    // Data falls back to way 0 on a miss
    function automatic lsu_pkg::dc_way_t probe(input lsu_pkg::dc_set_t set,
                                               input lsu_pkg::dc_tag_t tag,
                                               output logic hit,
                                               output lsu_pkg::data_t data);
        lsu_pkg::dc_way_t way;
        hit  = 1'b0;
        way  = '0;
        data = line_data[0][set];
        for (int w = 0; w < WAYS; w++) begin
            if (line_valid[w][set] && (line_tag[w][set] == tag)) begin
                hit  = 1'b1;
                way  = lsu_pkg::dc_way_t'(w);
                data = line_data[w][set];
            end
        end
        return way;
    endfunction

    // Store lookup from the retiring store queue slot
    always_comb begin
        o_hit_way = probe(i_lookup_set, i_lookup_tag, o_hit, o_hit_data);
    end

    // Load lookup for the external read port
    always_comb begin
        void'(probe(ld_set, i_ld_addr[`LSU_ADDR_WIDTH-1:TAG_LO], o_ld_hit, o_ld_data));
    end

    // A fill marks the victim line valid and moves the set's victim pointer on
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int s = 0; s < SETS; s++) begin
                victim[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    line_valid[w][s] <= 1'b0;
                end
            end
        end else if (i_fill_en) begin
            line_valid[fill_way][fill_set] <= 1'b1;
            victim[fill_set]               <= fill_way + 1'b1;
        end
    end

    // Store writes go to the hit way and fills replace the victim way
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_data[o_hit_way][i_lookup_set] <= i_wr_data;
        end
        if (i_fill_en) begin
            line_tag[fill_way][fill_set]  <= i_fill_addr[`LSU_ADDR_WIDTH-1:TAG_LO];
            line_data[fill_way][fill_set] <= i_fill_data;
        end
    end

    // The external fill source must keep away from the set being written by a retire
    a_no_wr_fill_clash: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_wr_en && i_fill_en && (i_lookup_set == fill_set)));

endmodule

`default_nettype wire

// ==== rtl/lsu_mshq.sv ====
// Miss holding queue merging store misses per word and draining them under memory credits
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_mshq (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       i_push,
    input  wire lsu_pkg::addr_t       i_addr,
    input  wire lsu_pkg::data_t       i_data,
    input  wire lsu_pkg::byte_mask_t  i_mask,
    output logic                      o_full,
    output logic                      o_mem_req_valid,
    output lsu_pkg::addr_t            o_mem_req_addr,
    output lsu_pkg::data_t            o_mem_req_data,
    output lsu_pkg::byte_mask_t       o_mem_req_mask,
    input  wire                       i_mem_credit
);

    localparam int DEPTH  = `LSU_MSHQ_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CRED_W = $clog2(`LSU_MEM_CREDITS + 1);

    logic [DEPTH-1:0]    ent_valid;
    lsu_pkg::addr_t      ent_addr [DEPTH];
    lsu_pkg::data_t      ent_data [DEPTH];
    lsu_pkg::byte_mask_t ent_mask [DEPTH];

    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [CRED_W-1:0] credits;
    logic [PTR_W-1:0]  merge_idx;
    logic              merge_hit;
    logic              send;
    logic              push_new;

    // Wraps a queue pointer
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head goes out whenever memory has a credit left
    assign send            = ent_valid[head] && (credits != '0);
    assign o_mem_req_valid = send;
    assign o_mem_req_addr  = ent_addr[head];
    assign o_mem_req_data  = ent_data[head];
    assign o_mem_req_mask  = ent_mask[head];

    // A held word absorbs the push unless that entry leaves this cycle
    always_comb begin
        merge_hit = 1'b0;
        merge_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && (ent_addr[i] == i_addr) && !(send && (head == PTR_W'(i)))) begin
                merge_hit = 1'b1;
                merge_idx = PTR_W'(i);
            end
        end
    end

    // Full only matters for a push that needs its own entry
    assign o_full   = (&ent_valid) && !merge_hit;
    assign push_new = i_push && !merge_hit && !(&ent_valid);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
            credits   <= CRED_W'(`LSU_MEM_CREDITS);
        end else begin
            if (send) begin
                ent_valid[head] <= 1'b0;
                head            <= bump(head);
            end
            if (push_new) begin
                ent_valid[tail] <= 1'b1;
                tail            <= bump(tail);
            end
            credits <= credits - CRED_W'(send) + CRED_W'(i_mem_credit);
        end
    end

    // New entries take the whole push, merges overwrite enabled bytes only
    always_ff @(posedge clk) begin
        if (push_new) begin
            ent_addr[tail] <= i_addr;
            ent_data[tail] <= i_data;
            ent_mask[tail] <= i_mask;
        end else if (i_push && merge_hit) begin
            for (int b = 0; b < `LSU_DATA_WIDTH / 8; b++) begin
                if (i_mask[b]) begin
                    ent_data[merge_idx][b*8 +: 8] <= i_data[b*8 +: 8];
                end
            end
            ent_mask[merge_idx] <= ent_mask[merge_idx] | i_mask;
        end
    end

    // Memory never returns more credits than it was given at reset
    a_credit_bound: assert property (@(posedge clk) disable iff (!n_rst)
        credits <= CRED_W'(`LSU_MEM_CREDITS));

endmodule

`default_nettype wire

// ==== rtl/lsu_store_path.sv ====
// Store retirement path joining the store queue, the data cache and the miss holding queue
`timescale 1ns/1ps
`default_nettype none

module lsu_store_path (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       i_flush,
    output logic                      o_sq_full,
    input  wire                       i_alloc_en,
    input  wire lsu_pkg::data_t       i_alloc_data,
    input  wire lsu_pkg::addr_t       i_alloc_addr,
    input  wire lsu_pkg::lsu_func_t   i_alloc_func,
    input  wire lsu_pkg::rob_tag_t    i_alloc_tag,
    input  wire                       i_rob_retire_en,
    input  wire lsu_pkg::rob_tag_t    i_rob_retire_tag,
    output logic                      o_rob_retire_stall,
    input  wire                       i_fill_en,
    input  wire lsu_pkg::addr_t       i_fill_addr,
    input  wire lsu_pkg::data_t       i_fill_data,
    input  wire lsu_pkg::addr_t       i_ld_addr,
    output logic                      o_ld_hit,
    output lsu_pkg::data_t            o_ld_data,
    output logic                      o_mem_req_valid,
    output lsu_pkg::addr_t            o_mem_req_addr,
    output lsu_pkg::data_t            o_mem_req_data,
    output lsu_pkg::byte_mask_t       o_mem_req_mask,
    input  wire                       i_mem_credit
);

    // Retire lookup between the store queue and the cache
    lsu_pkg::dc_set_t    dc_set;
    lsu_pkg::dc_tag_t    dc_tag;
    logic                dc_hit;
    lsu_pkg::data_t      dc_data;
    logic                dc_wr_en;
    lsu_pkg::data_t      dc_wr_data;

    // Store misses handed to the miss queue
    logic                mshq_push;
    lsu_pkg::addr_t      mshq_addr;
    lsu_pkg::data_t      mshq_data;
    lsu_pkg::byte_mask_t mshq_mask;
    logic                mshq_full;

    lsu_sq u_sq (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush), .o_full(o_sq_full),
        .i_alloc_en(i_alloc_en), .i_alloc_data(i_alloc_data), .i_alloc_addr(i_alloc_addr),
        .i_alloc_func(i_alloc_func), .i_alloc_tag(i_alloc_tag),
        .i_rob_retire_en(i_rob_retire_en), .i_rob_retire_tag(i_rob_retire_tag),
        .o_rob_retire_stall(o_rob_retire_stall), .o_dc_set(dc_set), .o_dc_tag(dc_tag),
        .i_dc_hit(dc_hit), .i_dc_data(dc_data), .o_dc_wr_en(dc_wr_en),
        .o_dc_wr_data(dc_wr_data), .o_mshq_push(mshq_push), .o_mshq_addr(mshq_addr),
        .o_mshq_data(mshq_data), .o_mshq_mask(mshq_mask), .i_mshq_full(mshq_full)
    );

    // The hit way stays inside the cache where it steers the store write
    lsu_dcache u_dcache (
        .clk(clk), .n_rst(n_rst), .i_lookup_set(dc_set), .i_lookup_tag(dc_tag),
        .o_hit(dc_hit), .o_hit_way(), .o_hit_data(dc_data), .i_wr_en(dc_wr_en),
        .i_wr_data(dc_wr_data), .i_ld_addr(i_ld_addr), .o_ld_hit(o_ld_hit),
        .o_ld_data(o_ld_data), .i_fill_en(i_fill_en), .i_fill_addr(i_fill_addr),
        .i_fill_data(i_fill_data)
    );

    lsu_mshq u_mshq (
        .clk(clk), .n_rst(n_rst), .i_push(mshq_push), .i_addr(mshq_addr),
        .i_data(mshq_data), .i_mask(mshq_mask), .o_full(mshq_full),
        .o_mem_req_valid(o_mem_req_valid), .o_mem_req_addr(o_mem_req_addr),
        .o_mem_req_data(o_mem_req_data), .o_mem_req_mask(o_mem_req_mask),
        .i_mem_credit(i_mem_credit)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_store_path.sv ====
// Testbench for the LSU store path with a table of operations, a cache and memory model
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_store_path;

    typedef enum {OP_ALLOC, OP_RETIRE, OP_FILL, OP_LOAD, OP_CREDIT, OP_FLUSH,
                  OP_IDLE, OP_FULL, OP_DRAIN} op_t;

    // One table row where chk holds the expected full, stall or load hit flag
    typedef struct {
        op_t                op;
        logic [4:0]         tag;
        logic [15:0]        addr;
        lsu_pkg::lsu_func_t func;
        logic               chk;
    } row_t;

    localparam logic [15:0] A  = 16'h0100;
    localparam logic [15:0] B  = 16'h0104;
    localparam logic [15:0] M1 = 16'h0200;
    localparam logic [15:0] M2 = 16'h0208;
    localparam logic [15:0] M3 = 16'h020C;
    localparam logic [15:0] M4 = 16'h0300;
    localparam logic [15:0] M5 = 16'h0400;

    logic clk;
    logic n_rst;
    logic i_flush, i_alloc_en, i_rob_retire_en, i_fill_en, i_mem_credit;
    logic [31:0] i_alloc_data, i_fill_data;
    logic [15:0] i_alloc_addr, i_fill_addr, i_ld_addr;
    lsu_pkg::lsu_func_t i_alloc_func;
    logic [4:0] i_alloc_tag, i_rob_retire_tag;
    logic o_sq_full, o_rob_retire_stall, o_ld_hit, o_mem_req_valid;
    logic [31:0] o_ld_data, o_mem_req_data;
    logic [15:0] o_mem_req_addr;
    logic [3:0] o_mem_req_mask;

    row_t rows[$];
    int   timeout_cycles = 1000;
    int   cycle_count = 0;
    int   mdl_credits = `LSU_MEM_CREDITS;

    // A stalled retire keeps its tag on the ROB port until a later retire row goes through
    bit   retire_held = 1'b0;

    // Reference state with cache words by word address and pending memory requests in order
    logic [31:0]        cache_mdl [logic [15:0]];
    logic [15:0]        st_addr [32];
    logic [31:0]        st_data [32];
    lsu_pkg::lsu_func_t st_func [32];
    logic [15:0]        req_addr_q[$];
    logic [31:0]        req_data_q[$];
    logic [3:0]         req_mask_q[$];
    logic [31:0]        mon_bits;

    lsu_store_path u_lsu_store_path (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush), .o_sq_full(o_sq_full),
        .i_alloc_en(i_alloc_en), .i_alloc_data(i_alloc_data), .i_alloc_addr(i_alloc_addr),
        .i_alloc_func(i_alloc_func), .i_alloc_tag(i_alloc_tag),
        .i_rob_retire_en(i_rob_retire_en), .i_rob_retire_tag(i_rob_retire_tag),
        .o_rob_retire_stall(o_rob_retire_stall), .i_fill_en(i_fill_en),
        .i_fill_addr(i_fill_addr), .i_fill_data(i_fill_data), .i_ld_addr(i_ld_addr),
        .o_ld_hit(o_ld_hit), .o_ld_data(o_ld_data), .o_mem_req_valid(o_mem_req_valid),
        .o_mem_req_addr(o_mem_req_addr), .o_mem_req_data(o_mem_req_data),
        .o_mem_req_mask(o_mem_req_mask), .i_mem_credit(i_mem_credit)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    // Byte enables by store type since sub-word stores always land in the low bytes
    function automatic logic [3:0] mask_of(input lsu_pkg::lsu_func_t func);
        case (func)
            lsu_pkg::SB: return 4'b0001;
            lsu_pkg::SH: return 4'b0011;
            default:     return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] expand_mask(input logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    // Enabled bytes come from the new word and the rest keep the old word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] mask);
        return (old_w & ~expand_mask(mask)) | (new_w & expand_mask(mask));
    endfunction

    function automatic void add_row(input op_t op, input logic [4:0] tag,
                                    input logic [15:0] addr, input lsu_pkg::lsu_func_t func,
                                    input logic chk);
        row_t r;
        r.op   = op;
        r.tag  = tag;
        r.addr = addr;
        r.func = func;
        r.chk  = chk;
        rows.push_back(r);
    endfunction

    task automatic drive_idle();
        i_flush         = 1'b0;
        i_alloc_en      = 1'b0;
        i_fill_en       = 1'b0;
        i_mem_credit    = 1'b0;
        if (!retire_held) begin
            i_rob_retire_en = 1'b0;
        end
    endtask

    // A retired store updates the cached word on a hit and otherwise joins or merges a request
    task automatic retire_model(input logic [4:0] tag);
        logic [15:0] wa;
        logic [3:0]  mask;
        bit          found;
        wa    = {st_addr[tag][15:2], 2'b00};
        mask  = mask_of(st_func[tag]);
        found = 0;
        if (cache_mdl.exists(wa)) begin
            cache_mdl[wa] = merge_bytes(cache_mdl[wa], st_data[tag], mask);
        end else begin
            foreach (req_addr_q[i]) begin
                if (req_addr_q[i] == wa) begin
                    req_data_q[i] = merge_bytes(req_data_q[i], st_data[tag], mask);
                    req_mask_q[i] = req_mask_q[i] | mask;
                    found = 1;
                end
            end
            if (!found) begin
                req_addr_q.push_back(wa);
                req_data_q.push_back(st_data[tag]);
                req_mask_q.push_back(mask);
            end
        end
    endtask

    // Each row starts 1 ns after a rising edge and checks outputs at the falling edge
    task automatic run_row(input int idx, input row_t r);
        logic [31:0] word;
        logic [15:0] wa;
        wa = {r.addr[15:2], 2'b00};
        // Drain rows wait until memory has taken every pending request
        if (r.op == OP_DRAIN) begin
            while (req_addr_q.size() != 0) begin
                @(posedge clk);
                #1;
            end
        end
        case (r.op)
            OP_ALLOC: begin
                check_value(32'(o_sq_full), 0, $sformatf("row %0d alloc while full", idx));
                word         = $urandom;
                i_alloc_en   = 1'b1;
                i_alloc_data = word;
                i_alloc_addr = r.addr;
                i_alloc_func = r.func;
                i_alloc_tag  = r.tag;
                st_addr[r.tag] = r.addr;
                st_data[r.tag] = word;
                st_func[r.tag] = r.func;
            end
            OP_RETIRE: begin
                i_rob_retire_en  = 1'b1;
                i_rob_retire_tag = r.tag;
            end
            OP_FILL: begin
                // Fill words follow the address so every line holds a distinct value
                word          = {~r.addr, r.addr};
                i_fill_en     = 1'b1;
                i_fill_addr   = r.addr;
                i_fill_data   = word;
                cache_mdl[wa] = word;
            end
            OP_LOAD:   i_ld_addr = r.addr;
            OP_CREDIT: i_mem_credit = 1'b1;
            OP_FLUSH:  i_flush = 1'b1;
            default: ;
        endcase
        @(negedge clk);
        if (r.op == OP_RETIRE) begin
            check_value(32'(o_rob_retire_stall), 32'(r.chk), $sformatf("row %0d stall", idx));
        end else if (retire_held) begin
            check_value(32'(o_rob_retire_stall), 1, $sformatf("row %0d held stall", idx));
        end
        if (r.op == OP_FULL) begin
            check_value(32'(o_sq_full), 32'(r.chk), $sformatf("row %0d queue full", idx));
        end
        if (r.op == OP_LOAD) begin
            check_value(32'(o_ld_hit), 32'(r.chk), $sformatf("row %0d load hit", idx));
            if (r.chk) begin
                check_value(o_ld_data, cache_mdl[wa], $sformatf("row %0d load data", idx));
            end
        end
        @(posedge clk);
        #1;
        if (r.op == OP_RETIRE) begin
            retire_held = r.chk;
        end
        if (r.op == OP_RETIRE && !r.chk) begin
            retire_model(r.tag);
        end
        drive_idle();
    endtask

    task automatic build_table();
        // Fills then SW, SB and SH hits to one word and a flush of a full queue
        add_row(OP_FILL, 0, A, lsu_pkg::SW, 0);
        add_row(OP_FILL, 0, B, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, A, lsu_pkg::SW, 1);
        add_row(OP_LOAD, 0, M1, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 0, A, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 1, A + 16'd1, lsu_pkg::SB, 0);
        add_row(OP_ALLOC, 2, A + 16'd2, lsu_pkg::SH, 0);
        add_row(OP_ALLOC, 3, B, lsu_pkg::SW, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 1);
        add_row(OP_RETIRE, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, A, lsu_pkg::SW, 1);
        add_row(OP_RETIRE, 1, 0, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, A, lsu_pkg::SW, 1);
        add_row(OP_RETIRE, 2, 0, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, A, lsu_pkg::SW, 1);
        add_row(OP_ALLOC, 4, M1, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 5, M2, lsu_pkg::SH, 0);
        add_row(OP_ALLOC, 6, M3, lsu_pkg::SB, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 1);
        add_row(OP_FLUSH, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 7, B, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 7, 0, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, B, lsu_pkg::SW, 1);
        // Two misses drain in order and use up both credits
        add_row(OP_ALLOC, 8, M1, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 9, M2, lsu_pkg::SH, 0);
        add_row(OP_RETIRE, 8, 0, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 9, 0, lsu_pkg::SW, 0);
        add_row(OP_DRAIN, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_LOAD, 0, M1, lsu_pkg::SW, 0);
        // Without credits the miss queue fills, a held word merges and a third word stalls
        add_row(OP_ALLOC, 10, M3, lsu_pkg::SH, 0);
        add_row(OP_ALLOC, 11, M4, lsu_pkg::SW, 0);
        add_row(OP_ALLOC, 12, M3 + 16'd1, lsu_pkg::SB, 0);
        add_row(OP_ALLOC, 13, M5, lsu_pkg::SW, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 1);
        add_row(OP_RETIRE, 10, 0, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 11, 0, lsu_pkg::SW, 0);
        add_row(OP_IDLE, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 12, 0, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 13, 0, lsu_pkg::SW, 1);
        // Credits come back while the ROB holds the stalled tag until it retires
        add_row(OP_CREDIT, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_CREDIT, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_RETIRE, 13, 0, lsu_pkg::SW, 0);
        add_row(OP_CREDIT, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_DRAIN, 0, 0, lsu_pkg::SW, 0);
        add_row(OP_FULL, 0, 0, lsu_pkg::SW, 0);
    endtask

    // Every memory request must match the oldest pending one and hold a credit
    always @(negedge clk) begin
        if (n_rst && o_mem_req_valid) begin
            check_value(32'(req_addr_q.size() != 0), 1, "memory request with none pending");
            check_value(32'(mdl_credits != 0), 1, "memory request sent with zero credits");
            mon_bits = expand_mask(req_mask_q[0]);
            check_value(32'(o_mem_req_addr), 32'(req_addr_q[0]), "memory request address");
            check_value(32'(o_mem_req_mask), 32'(req_mask_q[0]), "memory request mask");
            check_value(o_mem_req_data & mon_bits, req_data_q[0] & mon_bits,
                        "memory request data");
            void'(req_addr_q.pop_front());
            void'(req_data_q.pop_front());
            void'(req_mask_q.pop_front());
            mdl_credits = mdl_credits - 1;
        end
        if (n_rst && i_mem_credit) begin
            mdl_credits = mdl_credits + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("The run timed out after %0d cycles without finishing", cycle_count);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(98));
        n_rst        = 1'b0;
        drive_idle();
        i_rob_retire_en = 1'b0;
        i_alloc_data = '0;
        i_alloc_addr = '0;
        i_alloc_func = lsu_pkg::SW;
        i_alloc_tag  = '0;
        i_rob_retire_tag = '0;
        i_fill_addr  = '0;
        i_fill_data  = '0;
        i_ld_addr    = '0;
        build_table();
        timeout_cycles = rows.size() * 4 + 50;
        repeat (4) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        check_value(32'(o_sq_full), 0, "store queue full after reset");
        check_value(32'(o_rob_retire_stall), 0, "retire stall after reset");
        check_value(32'(o_mem_req_valid), 0, "memory request after reset");
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_sq.sv
rtl/lsu_dcache.sv
rtl/lsu_mshq.sv
rtl/lsu_store_path.sv
testbench/tb_lsu_store_path.sv
